/* design/life_pkg.sv */
// Fixed 8x8 board only; cell index is row*8+col, bit 63 is row 7 col 7, no wrap at edges
`default_nettype none

package life_pkg;

    // Board geometry
    localparam int grid_width  = 8;                       // Columns per row
    localparam int grid_height = 8;                       // Rows per board
    localparam int board_size  = grid_width * grid_height; // Cells, also serial frame length

    // One bit per cell, set for a live cell
    typedef logic [board_size-1:0] board_t;

    // Operating mode, driven straight from the mode pins
    typedef enum logic [1:0] {
        mode_load   = 2'b00, // Shift seed in, one bit per clock
        mode_run    = 2'b01, // One generation per clock
        mode_output = 2'b10, // Shift board out, MSB first
        mode_stop   = 2'b11  // Hold everything
    } mode_e;

    // Serial frames are MSB first in both directions, so the
    // first bit in ends up as cell 63 after a full load

endpackage : life_pkg

`default_nettype wire

/* design/life_bus_if.sv */
// Internal bundle only; carries no handshake, the mode pins pace every block
`timescale 1ns/100ps
`default_nettype none

interface life_bus_if import life_pkg::*; ();

    mode_e  mode;          // Current operating mode
    board_t seed_board;    // Post-shift loader value
    board_t current_board; // Generation held in memory
    board_t next_board;    // Combinational next generation

    modport top (
        output mode          // Cast from the mode pins
    );

    modport loader (
        input  mode,
        output seed_board
    );

    modport memory (
        input  mode,
        input  seed_board,
        input  next_board,
        output current_board
    );

    modport grid (
        input  current_board,
        output next_board
    );

    modport unloader (
        input mode,
        input next_board
    );

endinterface : life_bus_if

`default_nettype wire

/* design/serial_loader.sv */
// Shifts only in load mode; seed_board already includes the current data_in bit
`timescale 1ns/100ps
`default_nettype none

module serial_loader import life_pkg::*; (
    input  logic clk,          // System clock
    input  logic rst_n,        // Async reset, active low
    input  logic data_in,      // Serial seed, MSB first
    life_bus_if.loader bus     // Mode in, seed board out
);

    board_t shift_q;           // Bits received so far

    // Value the register takes at this edge, so memory
    // sees the whole frame on the 64th load edge
    assign bus.seed_board = {shift_q[board_size-2:0], data_in};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shift_q <= '0;                      // Empty frame
        end else if (bus.mode == mode_load) begin
            shift_q <= bus.seed_board;          // Shift left, new bit in 0
        end
    end
    // Run, output and stop leave the partial frame alone,
    // so a load can be paused with stop cycles

endmodule : serial_loader

`default_nettype wire

/* design/board_memory.sv */
// Single board register; loads every load edge, so only the 64th load edge leaves a full seed
`timescale 1ns/100ps
`default_nettype none

module board_memory import life_pkg::*; (
    input  logic clk,          // System clock
    input  logic rst_n,        // Async reset, active low
    life_bus_if.memory bus     // Seed and next in, current out
);

    board_t board_q;           // Generation held between clocks
    board_t board_d;           // Value for the next edge

    // Source select by mode
    always_comb begin
        board_d = board_q;                          // Hold by default
        case (bus.mode)
            mode_load:   board_d = bus.seed_board;  // Partial or full seed
            mode_run:    board_d = bus.next_board;  // Advance one generation
            mode_output: board_d = board_q;         // Unloader is shifting
            mode_stop:   board_d = board_q;         // Freeze
            default:     board_d = board_q;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            board_q <= '0;     // Dead board
        end else begin
            board_q <= board_d;
        end
    end

    assign bus.current_board = board_q; // Feeds the cell grid

endmodule : board_memory

`default_nettype wire

/* design/cell_grid.sv */
// Pure combinational rule for all cells; off-grid neighbors are dead, no wrap-around
`timescale 1ns/100ps
`default_nettype none

module cell_grid import life_pkg::*; (
    life_bus_if.grid bus       // Current board in, next board out
);

    // Board with a ring of dead cells around it
    logic [grid_height+1:0][grid_width+1:0] padded;

    always_comb begin
        padded = '0;                            // Border stays dead
        for (int r = 0; r < grid_height; r++) begin
            for (int c = 0; c < grid_width; c++) begin
                padded[r+1][c+1] = bus.current_board[r*grid_width + c];
            end
        end
    end

    for (genvar r = 0; r < grid_height; r++) begin : g_row
        for (genvar c = 0; c < grid_width; c++) begin : g_col
            logic [3:0] count;  // Live neighbors, 0 to 8
            logic       alive;  // This cell now

            // Cell (r,c) sits at padded[r+1][c+1]
            assign alive = padded[r+1][c+1];

            assign count = 4'(padded[r][c])       // Row above
                         + 4'(padded[r][c+1])
                         + 4'(padded[r][c+2])
                         + 4'(padded[r+1][c])     // Same row
                         + 4'(padded[r+1][c+2])
                         + 4'(padded[r+2][c])     // Row below
                         + 4'(padded[r+2][c+1])
                         + 4'(padded[r+2][c+2]);

            // Birth on 3, survival on 2 or 3
            assign bus.next_board[r*grid_width + c] =
                (count == 4'd3) || (alive && (count == 4'd2));
        end
    end

    // Row 0 and row 7 see a dead row beyond them, likewise
    // columns 0 and 7, so a glider into a corner just stops

endmodule : cell_grid

`default_nettype wire

/* design/serial_unloader.sv */
// data_out is only meaningful in output mode after a run; no valid flag is given
`timescale 1ns/100ps
`default_nettype none

module serial_unloader import life_pkg::*; (
    input  logic clk,          // System clock
    input  logic rst_n,        // Async reset, active low
    life_bus_if.unloader bus,  // Mode and next board in
    output logic data_out      // Serial board, MSB first
);

    board_t out_q;             // Frame being shifted out

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_q <= '0;                                 // data_out reads 0
        end else begin
            case (bus.mode)
                mode_load,
                mode_run: begin
                    out_q <= bus.next_board;             // Track memory's next value
                end
                mode_output: begin
                    out_q <= {out_q[board_size-2:0], 1'b0}; // Shift left, zero fill
                end
                default: begin
                    out_q <= out_q;                      // Stop holds
                end
            endcase
        end
    end

    // After a run edge memory holds generation N and so does
    // this register, since both sampled the same next_board

    assign data_out = out_q[board_size-1]; // Cell 63 leaves first

endmodule : serial_unloader

`default_nettype wire

/* design/life_top.sv */
// Mode pins are the only control: 64 load cycles, then run, then 64 output cycles; stop anywhere
`timescale 1ns/100ps
`default_nettype none

module life_top import life_pkg::*; (
    input  logic       clk,      // System clock
    input  logic       rst_n,    // Async reset, active low
    input  logic [1:0] mode,     // 00 load, 01 run, 10 output, 11 stop
    input  logic       data_in,  // Serial seed in
    output logic       data_out  // Serial board out
);

    life_bus_if bus ();          // Shared internal bundle

    assign bus.mode = mode_e'(mode); // All four codes are defined

    // Serial to parallel seed path
    serial_loader u_loader (
        .clk     (clk),
        .rst_n   (rst_n),
        .data_in (data_in),
        .bus     (bus.loader)
    );

    // Holds the current generation
    board_memory u_memory (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bus.memory)
    );

    // Life rule, zero cycles
    cell_grid u_grid (
        .bus (bus.grid)
    );

    // Parallel to serial result path
    serial_unloader u_unloader (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus      (bus.unloader),
        .data_out (data_out)
    );

    // Loader feeds memory, memory feeds grid, grid feeds
    // both memory and unloader in a single loop

endmodule : life_top

`default_nettype wire

/* verification/life_checker.sv */
// Bound into board_memory; watches only bus signals and assumes mode is never unknown after reset
`timescale 1ns/100ps
`default_nettype none

module life_checker import life_pkg::*; (
    input logic   clk,           // System clock
    input logic   rst_n,         // Async reset, active low
    input mode_e  mode,          // Mode seen by the memory
    input board_t seed_board,    // Loader's post-shift value
    input board_t current_board  // Board register output
);

    int fail_count = 0;          // Read by the testbench at the end

    // Board is dead when reset lets go
    reset_clear: assert property (@(posedge clk) $rose(rst_n) |-> current_board == '0)
        else begin fail_count++; $error("current_board not clear after reset"); end

    // Output and stop freeze the generation
    idle_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (mode == mode_output || mode == mode_stop) |=> $stable(current_board))
        else begin fail_count++; $error("current_board moved in output or stop mode"); end

    // Every load edge copies the loader's shifted value
    load_copy: assert property (@(posedge clk) disable iff (!rst_n)
        (mode == mode_load) |=> current_board == $past(seed_board))
        else begin fail_count++; $error("current_board missed seed_board on a load edge"); end

endmodule : life_checker

bind board_memory life_checker u_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .mode          (bus.mode),
    .seed_board    (bus.seed_board),
    .current_board (bus.current_board)
);

`default_nettype wire

/* verification/life_tb.sv */
// Random boards from seed 63; inputs change on falling edges, data_out is read there too
`timescale 1ns/100ps
`default_nettype none

module life_tb import life_pkg::*; ();

    localparam int num_tests   = 48;                              // Upper bound on frames played
    localparam int test_cycles = board_size + 16 + board_size + 8; // Load, run, out, slack
    localparam int watchdog_ns = num_tests * test_cycles * 10 * 2; // Doubled for margin

    logic       clk;
    logic       rst_n;
    logic [1:0] mode;
    logic       data_in;
    logic       data_out;

    int     seed   = 63;         // $random state
    int     errors = 0;
    int     checks = 0;
    int     gens;
    board_t got_a;
    board_t got_b;
    board_t want;
    board_t pat;

    life_top uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .mode     (mode),
        .data_in  (data_in),
        .data_out (data_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period
    end

    function automatic board_t random_board();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return $unsigned(r) % n;
    endfunction

    function automatic int cell_idx(input int r, input int c);
        return r * grid_width + c; // Row major, row 7 col 7 is bit 63
    endfunction

    // Reference rule, neighbors outside the grid are dead
    task automatic life_model(input board_t cur, output board_t nxt);
        int n;
        int rr;
        int cc;
        nxt = '0;
        for (int r = 0; r < grid_height; r++) begin
            for (int c = 0; c < grid_width; c++) begin
                n = 0;
                for (int dr = -1; dr <= 1; dr++) begin
                    for (int dc = -1; dc <= 1; dc++) begin
                        rr = r + dr;
                        cc = c + dc;
                        if ((dr != 0 || dc != 0) && rr >= 0 && rr < grid_height
                                && cc >= 0 && cc < grid_width) begin
                            if (cur[cell_idx(rr, cc)]) n++;
                        end
                    end
                end
                if (n == 3 || (cur[cell_idx(r, c)] && n == 2)) nxt[cell_idx(r, c)] = 1'b1;
            end
        end
    endtask

    task automatic evolve(input board_t start, input int n, output board_t res);
        res = start;
        repeat (n) life_model(res, res);
    endtask

    task automatic check_board(input string name, input board_t exp, input board_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic drive_cycle(input mode_e m, input logic d);
        @(negedge clk);
        mode    = m;
        data_in = d;
    endtask

    task automatic insert_stops(input int n);
        int r;
        for (int i = 0; i < n; i++) begin
            r = $random(seed);
            drive_cycle(mode_stop, r[0]); // Noise on data_in must not matter
        end
    endtask

    task automatic load_board(input board_t b);
        for (int i = board_size - 1; i >= 0; i--) drive_cycle(mode_load, b[i]); // MSB first
    endtask

    task automatic run_gens(input int n);
        repeat (n) drive_cycle(mode_run, 1'b0);
    endtask

    // First bit is already on data_out, each output edge brings the next
    task automatic collect_board(output board_t b);
        b = '0;
        for (int i = board_size - 1; i >= 0; i--) begin
            @(negedge clk);
            b[i]    = data_out;
            mode    = mode_output;
            data_in = 1'b0;
        end
    endtask

    task automatic play(input board_t b, input int n, input bit with_stops, output board_t got);
        load_board(b);
        if (with_stops) insert_stops(rand_below(4));
        run_gens(n);
        if (with_stops) insert_stops(rand_below(4));
        collect_board(got);
        if (with_stops) insert_stops(rand_below(4));
    endtask

    task automatic check_play(input string name, input board_t b, input int n, output board_t got);
        board_t exp;
        play(b, n, 1'b0, got);
        evolve(b, n, exp);
        check_board(name, exp, got);
    endtask

    initial begin
        mode    = mode_stop;
        data_in = 1'b0;
        rst_n   = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("reset", 1'b0, data_out);

        for (int t = 0; t < 10; t++) check_play("one_gen", random_board(), 1, got_a);
        for (int t = 0; t < 10; t++) begin
            gens = 1 + rand_below(8);
            check_play("many_gen", random_board(), gens, got_a);
        end

        check_play("empty", '0, 3, got_a);
        check_board("empty_stays", '0, got_a);
        pat = '0;                                                  // Block in a corner
        pat[cell_idx(6, 6)] = 1'b1;
        pat[cell_idx(6, 7)] = 1'b1;
        pat[cell_idx(7, 6)] = 1'b1;
        pat[cell_idx(7, 7)] = 1'b1;
        check_play("block", pat, 4, got_a);
        check_board("block_still", pat, got_a);
        pat = '0;                                                  // Blinker away from edges
        pat[cell_idx(3, 2)] = 1'b1;
        pat[cell_idx(3, 3)] = 1'b1;
        pat[cell_idx(3, 4)] = 1'b1;
        check_play("blinker_1", pat, 1, got_a);
        check_play("blinker_2", pat, 2, got_b);
        check_board("blinker_period", pat, got_b);
        pat = '0;                                                  // Glider heading to row 7 col 7
        pat[cell_idx(0, 1)] = 1'b1;
        pat[cell_idx(1, 2)] = 1'b1;
        pat[cell_idx(2, 0)] = 1'b1;
        pat[cell_idx(2, 1)] = 1'b1;
        pat[cell_idx(2, 2)] = 1'b1;
        check_play("glider_32", pat, 32, got_a);
        check_play("glider_40", pat, 40, got_b);
        evolve(pat, 32, want);                                     // Frozen by generation 32
        check_board("glider_frozen", want, got_b);

        for (int t = 0; t < 6; t++) begin                          // Same frame with and without stops
            pat  = random_board();
            gens = 1 + rand_below(8);
            evolve(pat, gens, want);
            play(pat, gens, 1'b0, got_a);
            play(pat, gens, 1'b1, got_b);
            check_board("stop_plain", want, got_a);
            check_board("stop_inserted", want, got_b);
        end

        for (int t = 0; t < 3; t++) begin                          // New seed over an evolved board
            play(random_board(), 1 + rand_below(8), 1'b0, got_a);
            run_gens(3);
            gens = 1 + rand_below(8);
            check_play("reload", random_board(), gens, got_b);
        end

        errors += uut.u_memory.u_checker.fail_count;               // Assertion failures count too
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, simulation hung", watchdog_ns);
        $display("tests failed");
        $finish;
    end

endmodule : life_tb

`default_nettype wire

/* tb.f */
design/life_pkg.sv
design/life_bus_if.sv
design/serial_loader.sv
design/board_memory.sv
design/cell_grid.sv
design/serial_unloader.sv
design/life_top.sv
verification/life_checker.sv
verification/life_tb.sv

/* Makefile */
# Verilator flow for the Life engine testbench

VERILATOR ?= verilator
TOP       ?= life_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
FLAGS     ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf $(OBJ_DIR)
